//--- Bender.yml
package:
  name: dual_axil_regfile

sources:
  - common/iob_pkg.sv
  - common/axil_pkg.sv
  - axil2iob/axil2iob.sv
  - hdl/iob_arbiter.sv
  - hdl/iob_regfile.sv
  - hdl/dual_axil_regfile_top.sv
  - target: simulation
    files:
      - verification/tb_clock_gen.sv
      - verification/axil2iob_properties.sv
      - verification/tb_checker.sv
      - verification/tb_top.sv

//--- all.f
common/iob_pkg.sv
common/axil_pkg.sv
axil2iob/axil2iob.sv
hdl/iob_arbiter.sv
hdl/iob_regfile.sv
hdl/dual_axil_regfile_top.sv
verification/tb_clock_gen.sv
verification/axil2iob_properties.sv
verification/tb_checker.sv
verification/tb_top.sv

//--- axil2iob/axil2iob.sv
`timescale 1ns/100ps
`default_nettype none

module axil2iob (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  axil_pkg::axil_req_t axil_req_i,
  output axil_pkg::axil_rsp_t axil_rsp_o,
  output iob_pkg::iob_req_t   iob_req_o,
  input  iob_pkg::iob_rsp_t   iob_rsp_i
);

  import axil_pkg::*;
  import iob_pkg::*;

  logic              rd_req;
  logic              wr_req;
  logic              aw_fire;
  logic              w_fire;
  logic              r_fire;
  logic [ADDR_W-1:0] awaddr_q;
  logic              bvalid_q;
  logic              rvalid_q;
  logic [DATA_W-1:0] rdata_q;

  // Reads win over writes in the same cycle
  assign rd_req = axil_req_i.arvalid;
  // Writes with an empty strobe never reach the bus
  assign wr_req = axil_req_i.wvalid & (|axil_req_i.wstrb) & ~rd_req;

  assign aw_fire = axil_req_i.awvalid & axil_rsp_o.awready;
  assign w_fire  = axil_req_i.wvalid & axil_rsp_o.wready;
  assign r_fire  = rvalid_q & axil_req_i.rready;

  // Native request, fully combinational
  always_comb begin
    iob_req_o.avalid = rd_req | wr_req;
    if (rd_req) begin
      iob_req_o.addr = axil_req_i.araddr;
    end else if (axil_req_i.awvalid) begin
      iob_req_o.addr = axil_req_i.awaddr;
    end else begin
      // W arrived after its AW
      iob_req_o.addr = awaddr_q;
    end
    iob_req_o.wdata = axil_req_i.wdata;
    iob_req_o.wstrb = rd_req ? '0 : axil_req_i.wstrb;
  end

  // Keep the last accepted write address for a late W beat
  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      awaddr_q <= axil_req_i.awaddr;
    end
  end

  // Held so rdata stays stable until the master takes it
  always_ff @(posedge clk_i) begin
    if (iob_rsp_i.rvalid) begin
      rdata_q <= iob_rsp_i.rdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (w_fire) begin
        bvalid_q <= 1'b1;
      end else if (axil_req_i.bready) begin
        bvalid_q <= 1'b0;
      end

      if (iob_rsp_i.rvalid) begin
        rvalid_q <= 1'b1;
      end else if (r_fire) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_comb begin
    axil_rsp_o.awready = iob_rsp_i.ready;
    // No W acknowledge while a read takes the bus
    axil_rsp_o.wready  = iob_rsp_i.ready & ~rd_req;
    axil_rsp_o.bvalid  = bvalid_q;
    axil_rsp_o.bresp   = RESP_OKAY;
    axil_rsp_o.arready = iob_rsp_i.ready;
    axil_rsp_o.rvalid  = rvalid_q;
    axil_rsp_o.rdata   = rdata_q;
    axil_rsp_o.rresp   = RESP_OKAY;
  end

endmodule

`default_nettype wire

//--- common/axil_pkg.sv
`default_nettype none

package axil_pkg;

  // Same widths as the native bus behind the bridge
  localparam int AXIL_ADDR_W = iob_pkg::ADDR_W;
  localparam int AXIL_DATA_W = iob_pkg::DATA_W;
  localparam int AXIL_STRB_W = iob_pkg::STRB_W;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_e;

  // Everything driven by the master
  typedef struct packed {
    logic                   awvalid;
    logic [AXIL_ADDR_W-1:0] awaddr;
    logic                   wvalid;
    logic [AXIL_DATA_W-1:0] wdata;
    logic [AXIL_STRB_W-1:0] wstrb;
    logic                   bready;
    logic                   arvalid;
    logic [AXIL_ADDR_W-1:0] araddr;
    logic                   rready;
  } axil_req_t;

  // Everything driven by the slave
  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    axil_resp_e             bresp;
    logic                   arready;
    logic                   rvalid;
    logic [AXIL_DATA_W-1:0] rdata;
    axil_resp_e             rresp;
  } axil_rsp_t;

endpackage

`default_nettype wire

//--- common/iob_pkg.sv
`default_nettype none

package iob_pkg;

  // Native bus widths
  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // Register file geometry in 32-bit words
  localparam int REG_DEPTH   = 64;
  localparam int WORD_ADDR_W = $clog2(REG_DEPTH);
  localparam int BYTE_OFFS_W = $clog2(STRB_W);

  // Request from a master, a zero wstrb is a read
  typedef struct packed {
    logic              avalid;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } iob_req_t;

  // Response from a slave
  // rvalid is a single-cycle pulse one cycle after a read is accepted
  typedef struct packed {
    logic              ready;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
  } iob_rsp_t;

  typedef enum logic {
    ARB_IDLE      = 1'b0,
    ARB_READ_WAIT = 1'b1
  } arb_state_e;

endpackage

`default_nettype wire

//--- hdl/dual_axil_regfile_top.sv
`timescale 1ns/100ps
`default_nettype none

module dual_axil_regfile_top (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  axil_pkg::axil_req_t axil_a_req_i,
  output axil_pkg::axil_rsp_t axil_a_rsp_o,
  input  axil_pkg::axil_req_t axil_b_req_i,
  output axil_pkg::axil_rsp_t axil_b_rsp_o
);

  import iob_pkg::*;

  // Bridge side of the arbiter
  iob_req_t bridge_a_req;
  iob_rsp_t bridge_a_rsp;
  iob_req_t bridge_b_req;
  iob_rsp_t bridge_b_rsp;

  // Shared bus into the register file
  iob_req_t regfile_req;
  iob_rsp_t regfile_rsp;

  axil2iob u_bridge_a (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .axil_req_i (axil_a_req_i),
    .axil_rsp_o (axil_a_rsp_o),
    .iob_req_o  (bridge_a_req),
    .iob_rsp_i  (bridge_a_rsp)
  );

  axil2iob u_bridge_b (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .axil_req_i (axil_b_req_i),
    .axil_rsp_o (axil_b_rsp_o),
    .iob_req_o  (bridge_b_req),
    .iob_rsp_i  (bridge_b_rsp)
  );

  // Port A on m0, so it wins the first tie
  iob_arbiter u_arbiter (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .m0_req_i (bridge_a_req),
    .m1_req_i (bridge_b_req),
    .m0_rsp_o (bridge_a_rsp),
    .m1_rsp_o (bridge_b_rsp),
    .s_req_o  (regfile_req),
    .s_rsp_i  (regfile_rsp)
  );

  iob_regfile u_regfile (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .iob_req_i (regfile_req),
    .iob_rsp_o (regfile_rsp)
  );

endmodule

`default_nettype wire

//--- hdl/iob_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module iob_arbiter (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  iob_pkg::iob_req_t m0_req_i,
  input  iob_pkg::iob_req_t m1_req_i,
  output iob_pkg::iob_rsp_t m0_rsp_o,
  output iob_pkg::iob_rsp_t m1_rsp_o,
  output iob_pkg::iob_req_t s_req_o,
  input  iob_pkg::iob_rsp_t s_rsp_i
);

  import iob_pkg::*;

  arb_state_e state_q;
  logic       idle;
  logic       gnt0;
  logic       gnt1;
  logic       accept;
  logic       is_read;
  // Master served last, high for m1
  logic       last_m1_q;
  // Owner of the outstanding read, high for m1
  logic       owner_m1_q;

  assign idle = (state_q == ARB_IDLE);

  // Round robin, the master not served last wins a tie
  assign gnt0 = idle & m0_req_i.avalid & (~m1_req_i.avalid | last_m1_q);
  assign gnt1 = idle & m1_req_i.avalid & (~m0_req_i.avalid | ~last_m1_q);

  always_comb begin
    s_req_o        = gnt1 ? m1_req_i : m0_req_i;
    s_req_o.avalid = gnt0 | gnt1;
  end

  assign accept  = s_req_o.avalid & s_rsp_i.ready;
  assign is_read = ~|s_req_o.wstrb;

  // A master sees ready unless the peer holds the grant
  // or a read is still in flight
  always_comb begin
    m0_rsp_o.ready  = s_rsp_i.ready & idle & ~gnt1;
    m0_rsp_o.rvalid = s_rsp_i.rvalid & ~idle & ~owner_m1_q;
    m0_rsp_o.rdata  = s_rsp_i.rdata;

    m1_rsp_o.ready  = s_rsp_i.ready & idle & ~gnt0;
    m1_rsp_o.rvalid = s_rsp_i.rvalid & ~idle & owner_m1_q;
    m1_rsp_o.rdata  = s_rsp_i.rdata;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= ARB_IDLE;
      // Port A takes the first tie
      last_m1_q  <= 1'b1;
      owner_m1_q <= 1'b0;
    end else begin
      case (state_q)
        ARB_IDLE: begin
          if (accept) begin
            last_m1_q <= gnt1;
            if (is_read) begin
              state_q    <= ARB_READ_WAIT;
              owner_m1_q <= gnt1;
            end
          end
        end
        ARB_READ_WAIT: begin
          // Nobody is granted until the data comes back
          if (s_rsp_i.rvalid) begin
            state_q <= ARB_IDLE;
          end
        end
        default: begin
          state_q <= ARB_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/iob_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module iob_regfile (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  iob_pkg::iob_req_t iob_req_i,
  output iob_pkg::iob_rsp_t iob_rsp_o
);

  import iob_pkg::*;

  logic [DATA_W-1:0]      mem_q [REG_DEPTH];
  logic [WORD_ADDR_W-1:0] word_idx;
  logic                   accept;
  logic                   rd_accept;
  logic                   rvalid_q;
  logic [DATA_W-1:0]      rdata_q;

  // Word index, upper address bits beyond the depth are dropped
  assign word_idx  = iob_req_i.addr[BYTE_OFFS_W +: WORD_ADDR_W];
  assign accept    = iob_req_i.avalid & iob_rsp_o.ready;
  assign rd_accept = accept & ~|iob_req_i.wstrb;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < REG_DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else if (accept) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (iob_req_i.wstrb[b]) begin
          mem_q[word_idx][8*b +: 8] <= iob_req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_accept) begin
      rdata_q <= mem_q[word_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_accept;
    end
  end

  // Busy only while returning read data
  assign iob_rsp_o.ready  = ~rvalid_q;
  assign iob_rsp_o.rvalid = rvalid_q;
  assign iob_rsp_o.rdata  = rdata_q;

endmodule

`default_nettype wire

//--- verification/axil2iob_properties.sv
`timescale 1ns/100ps
`default_nettype none

module axil2iob_properties (
  input logic                clk_i,
  input logic                rst_n_i,
  input axil_pkg::axil_req_t axil_req_i,
  input axil_pkg::axil_rsp_t axil_rsp_i,
  input iob_pkg::iob_req_t   iob_req_i
);

  int fail_count = 0;

  a_b_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    axil_rsp_i.bvalid && !axil_req_i.bready |=> axil_rsp_i.bvalid)
    else begin
      fail_count++;
      $error("bvalid dropped before bready");
    end

  // Read data frozen while the master stalls
  a_r_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    axil_rsp_i.rvalid && !axil_req_i.rready |=>
      axil_rsp_i.rvalid && $stable(axil_rsp_i.rdata))
    else begin
      fail_count++;
      $error("rvalid or rdata changed before rready");
    end

  a_no_read_overlap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(axil_rsp_i.rvalid && axil_req_i.arvalid && iob_req_i.avalid))
    else begin
      fail_count++;
      $error("new read issued while a read response is pending");
    end

  a_reset_clear: assert property (@(posedge clk_i)
    !rst_n_i |=> !axil_rsp_i.bvalid && !axil_rsp_i.rvalid)
    else begin
      fail_count++;
      $error("bvalid or rvalid high after reset");
    end

endmodule

bind axil2iob axil2iob_properties u_props (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .axil_req_i (axil_req_i),
  .axil_rsp_i (axil_rsp_o),
  .iob_req_i  (iob_req_o)
);

`default_nettype wire

//--- verification/tb_checker.sv
`timescale 1ns/100ps
`default_nettype none

module tb_checker (
  input logic                clk_i,
  input logic                rst_n_i,
  input axil_pkg::axil_req_t a_req_i,
  input axil_pkg::axil_rsp_t a_rsp_i,
  input axil_pkg::axil_req_t b_req_i,
  input axil_pkg::axil_rsp_t b_rsp_i
);

  import axil_pkg::*;
  import iob_pkg::*;

  axil_req_t         req [2];
  axil_rsp_t         rsp [2];
  logic [DATA_W-1:0] shadow [REG_DEPTH];
  logic [ADDR_W-1:0] aw_last [2];
  logic [DATA_W-1:0] table_exp [2];
  logic [DATA_W-1:0] shadow_exp [2];
  int                exp_b [2];
  int                exp_r [2];
  int                seen_b [2];
  int                seen_r [2];
  logic              b_pend [2];
  logic              r_pend [2];
  int                last_served;
  int                error_count;
  int                n_pass;
  int                n_fail;
  logic              test_bad;
  string             test_name;

  assign req[0] = a_req_i;
  assign req[1] = b_req_i;
  assign rsp[0] = a_rsp_i;
  assign rsp[1] = b_rsp_i;

  // Byte address to word, wrapping at the register file depth
  function automatic int word_of(input logic [ADDR_W-1:0] addr);
    return (addr >> 2) % REG_DEPTH;
  endfunction

  function automatic string port_name(input int p);
    return (p == 0) ? "A" : "B";
  endfunction

  task automatic record_error(input string msg);
    $display("%s", msg);
    error_count++;
    test_bad = 1'b1;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_bad  = 1'b0;
    for (int p = 0; p < 2; p++) begin
      exp_b[p]  = 0;
      exp_r[p]  = 0;
      seen_b[p] = 0;
      seen_r[p] = 0;
    end
  endtask

  task automatic expect_write(input int p);
    exp_b[p]++;
  endtask

  task automatic expect_read(input int p, input logic [DATA_W-1:0] data);
    exp_r[p]++;
    table_exp[p] = data;
  endtask

  task automatic finish_test();
    for (int p = 0; p < 2; p++) begin
      if (seen_b[p] != exp_b[p]) begin
        record_error($sformatf("%s: port %s gave %0d write responses instead of %0d",
                               test_name, port_name(p), seen_b[p], exp_b[p]));
      end
      if (seen_r[p] != exp_r[p]) begin
        record_error($sformatf("%s: port %s gave %0d read responses instead of %0d",
                               test_name, port_name(p), seen_r[p], exp_r[p]));
      end
    end
    if (test_bad) begin
      n_fail++;
      $display("FAIL %s", test_name);
    end else begin
      n_pass++;
      $display("PASS %s", test_name);
    end
  endtask

  task automatic report();
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             n_pass + n_fail, n_pass, n_fail, error_count);
  endtask

  // Register file and bridges come out of reset cleared
  initial begin
    for (int i = 0; i < REG_DEPTH; i++) begin
      shadow[i] = '0;
    end
    for (int p = 0; p < 2; p++) begin
      b_pend[p] = 1'b0;
      r_pend[p] = 1'b0;
    end
    aw_last[0]  = '0;
    aw_last[1]  = '0;
    last_served = 1;
    error_count = 0;
    n_pass      = 0;
    n_fail      = 0;
  end

  always @(posedge clk_i) begin : watch
    logic [ADDR_W-1:0] waddr;
    logic              wants [2];
    logic              served [2];
    if (rst_n_i) begin
      for (int p = 0; p < 2; p++) begin
        wants[p]  = req[p].arvalid | (req[p].wvalid & (|req[p].wstrb));
        served[p] = (req[p].arvalid & rsp[p].arready) |
                    (req[p].wvalid & rsp[p].wready & (|req[p].wstrb));
      end
      // On a tie the port not served last must win
      for (int p = 0; p < 2; p++) begin
        if (served[p] && wants[1-p] && last_served == p) begin
          record_error($sformatf("mismatch %s tie winner: expected port %s actual port %s",
                                 test_name, port_name(1-p), port_name(p)));
        end
      end
      for (int p = 0; p < 2; p++) begin
        if (served[p]) begin
          last_served = p;
        end
        if (req[p].wvalid && rsp[p].wready && (|req[p].wstrb)) begin
          waddr = req[p].awvalid ? req[p].awaddr : aw_last[p];
          for (int b = 0; b < STRB_W; b++) begin
            if (req[p].wstrb[b]) begin
              shadow[word_of(waddr)][8*b +: 8] = req[p].wdata[8*b +: 8];
            end
          end
        end
        if (req[p].awvalid && rsp[p].awready) begin
          aw_last[p] = req[p].awaddr;
        end
        if (req[p].arvalid && rsp[p].arready) begin
          shadow_exp[p] = shadow[word_of(req[p].araddr)];
        end
        // A response counts once, from its first cycle until it is taken
        if (rsp[p].bvalid && !b_pend[p]) begin
          seen_b[p]++;
        end
        if (rsp[p].rvalid && !r_pend[p]) begin
          seen_r[p]++;
        end
        b_pend[p] = rsp[p].bvalid & ~req[p].bready;
        r_pend[p] = rsp[p].rvalid & ~req[p].rready;
        if (rsp[p].bvalid && req[p].bready && rsp[p].bresp !== RESP_OKAY) begin
          record_error($sformatf("mismatch %s port %s bresp: expected %b actual %b",
                                 test_name, port_name(p), RESP_OKAY, rsp[p].bresp));
        end
        if (rsp[p].rvalid && req[p].rready) begin
          if (rsp[p].rresp !== RESP_OKAY) begin
            record_error($sformatf("mismatch %s port %s rresp: expected %b actual %b",
                                   test_name, port_name(p), RESP_OKAY, rsp[p].rresp));
          end
          if (rsp[p].rdata !== table_exp[p]) begin
            record_error($sformatf("mismatch %s port %s: expected %h actual %h",
                                   test_name, port_name(p), table_exp[p], rsp[p].rdata));
          end
          if (rsp[p].rdata !== shadow_exp[p]) begin
            record_error($sformatf("mismatch %s port %s shadow: expected %h actual %h",
                                   test_name, port_name(p), shadow_exp[p], rsp[p].rdata));
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Low for 5 rising edges, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- verification/tb_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_top;

  import axil_pkg::*;
  import iob_pkg::*;

  localparam int PA  = 0;
  localparam int PB  = 1;
  localparam int PAB = 2;
  // Hold-off code for a random length
  localparam logic [3:0] HOLD_RAND = 4'd15;

  typedef struct packed {
    logic [1:0]        port;
    logic              is_read;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic              late_w;
    logic [3:0]        hold;
    logic [DATA_W-1:0] exp;
  } step_t;

  logic      clk;
  logic      rst_n;
  axil_req_t req [2];
  axil_rsp_t rsp [2];
  step_t     steps [$];
  string     names [$];
  int        limit = 0;
  int        cycles = 0;
  int        seed;
  int        hold;
  int        fails;

  tb_clock_gen u_clock (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  dual_axil_regfile_top dut_i (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .axil_a_req_i (req[0]),
    .axil_a_rsp_o (rsp[0]),
    .axil_b_req_i (req[1]),
    .axil_b_rsp_o (rsp[1])
  );

  tb_checker u_checker (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .a_req_i (req[0]),
    .a_rsp_i (rsp[0]),
    .b_req_i (req[1]),
    .b_rsp_i (rsp[1])
  );

  task automatic add_step(input string name, input int port, input logic is_read,
                          input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                          input logic [STRB_W-1:0] wstrb, input logic late_w,
                          input logic [3:0] hold_code, input logic [DATA_W-1:0] exp);
    step_t s;
    s.port    = port[1:0];
    s.is_read = is_read;
    s.addr    = addr;
    s.wdata   = wdata;
    s.wstrb   = wstrb;
    s.late_w  = late_w;
    s.hold    = hold_code;
    s.exp     = exp;
    steps.push_back(s);
    names.push_back(name);
  endtask

  task automatic take_b(input int p, input int hold_cycles);
    while (!rsp[p].bvalid) @(negedge clk);
    repeat (hold_cycles) @(negedge clk);
    req[p].bready = 1'b1;
    @(negedge clk);
    req[p].bready = 1'b0;
  endtask

  task automatic run_write(input int p, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] wstrb,
                           input logic late_w, input int hold_cycles);
    logic aw_done;
    logic w_done;
    aw_done = 1'b0;
    w_done  = 1'b0;
    @(negedge clk);
    req[p].awvalid = 1'b1;
    req[p].awaddr  = addr;
    req[p].wvalid  = ~late_w;
    req[p].wdata   = wdata;
    req[p].wstrb   = wstrb;
    while (!(aw_done && w_done)) begin
      @(posedge clk);
      aw_done = aw_done | (req[p].awvalid & rsp[p].awready);
      w_done  = w_done | (req[p].wvalid & rsp[p].wready);
      @(negedge clk);
      req[p].awvalid = req[p].awvalid & ~aw_done;
      // Once AW is taken the bridge must use its own copy of the address
      if (aw_done) begin
        req[p].awaddr = ~addr;
      end
      // A late W beat goes out once its AW is taken
      req[p].wvalid  = ~w_done & (req[p].wvalid | aw_done);
    end
    take_b(p, hold_cycles);
  endtask

  task automatic run_read(input int p, input logic [ADDR_W-1:0] addr, input int hold_cycles);
    logic done;
    done = 1'b0;
    @(negedge clk);
    req[p].arvalid = 1'b1;
    req[p].araddr  = addr;
    while (!done) begin
      @(posedge clk);
      done = rsp[p].arready;
      @(negedge clk);
    end
    req[p].arvalid = 1'b0;
    while (!rsp[p].rvalid) @(negedge clk);
    repeat (hold_cycles) @(negedge clk);
    req[p].rready = 1'b1;
    @(negedge clk);
    req[p].rready = 1'b0;
  endtask

  task automatic run_port(input int p, input step_t s, input int hold_cycles);
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] exp;
    addr  = s.addr;
    wdata = s.wdata;
    exp   = s.exp;
    // Port B of a paired step uses the next word with inverted data
    if (s.port == PAB && p == PB) begin
      addr  = s.addr + 8'd4;
      wdata = ~s.wdata;
      exp   = ~s.exp;
    end
    if (s.is_read) begin
      u_checker.expect_read(p, exp);
      run_read(p, addr, hold_cycles);
    end else begin
      u_checker.expect_write(p);
      run_write(p, addr, wdata, s.wstrb, s.late_w, hold_cycles);
    end
  endtask

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("timeout: no response after %0d cycles", limit);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    req[0] = '0;
    req[1] = '0;
    seed   = $urandom(32'h1aaf_4af9);
    // name, port, read, addr, wdata, wstrb, late W, hold, expected rdata
    add_step("a_read_reset", PA, 1'b1, 8'h10, 32'h0, 4'h0, 1'b0, 4'd0, 32'h0);
    add_step("a_write_word", PA, 1'b0, 8'h10, 32'hdead_beef, 4'hf, 1'b0, 4'd0, 32'h0);
    add_step("a_read_word", PA, 1'b1, 8'h10, 32'h0, 4'h0, 1'b0, 4'd1, 32'hdead_beef);
    add_step("b_write_base", PB, 1'b0, 8'h20, 32'h1122_3344, 4'hf, 1'b0, 4'd0, 32'h0);
    add_step("b_write_byte0", PB, 1'b0, 8'h20, 32'h0000_00aa, 4'h1, 1'b0, 4'd0, 32'h0);
    add_step("b_write_upper", PB, 1'b0, 8'h20, 32'hbbcc_0000, 4'hc, 1'b0, 4'd2, 32'h0);
    add_step("b_write_nostrb", PB, 1'b0, 8'h20, 32'hffff_ffff, 4'h0, 1'b0, 4'd0, 32'h0);
    add_step("b_read_merged", PB, 1'b1, 8'h20, 32'h0, 4'h0, 1'b0, 4'd0, 32'hbbcc_33aa);
    add_step("both_write", PAB, 1'b0, 8'h30, 32'ha5a5_0001, 4'hf, 1'b0, 4'd0, 32'h0);
    add_step("both_read", PAB, 1'b1, 8'h30, 32'h0, 4'h0, 1'b0, 4'd1, 32'ha5a5_0001);
    add_step("a_read_rhold", PA, 1'b1, 8'h10, 32'h0, 4'h0, 1'b0, HOLD_RAND, 32'hdead_beef);
    add_step("a_write_bhold", PA, 1'b0, 8'h40, 32'h0bad_f00d, 4'hf, 1'b0, HOLD_RAND, 32'h0);
    add_step("cross_b_read", PB, 1'b1, 8'h40, 32'h0, 4'h0, 1'b0, 4'd0, 32'h0bad_f00d);
    add_step("a_write_top", PA, 1'b0, 8'hfc, 32'h7e57_0fff, 4'hf, 1'b0, 4'd0, 32'h0);
    add_step("b_read_top", PB, 1'b1, 8'hfc, 32'h0, 4'h0, 1'b0, 4'd0, 32'h7e57_0fff);
    add_step("a_late_w", PA, 1'b0, 8'h50, 32'hc0de_cafe, 4'hf, 1'b1, 4'd0, 32'h0);
    add_step("a_read_late", PA, 1'b1, 8'h50, 32'h0, 4'h0, 1'b0, 4'd0, 32'hc0de_cafe);
    // Port A was served last, so port B takes this tie
    add_step("both_read_b_first", PAB, 1'b1, 8'h30, 32'h0, 4'h0, 1'b0, 4'd0, 32'ha5a5_0001);
    limit = steps.size() * 20 + 10;
    wait (rst_n);
    for (int i = 0; i < steps.size(); i++) begin
      hold = (steps[i].hold == HOLD_RAND) ? ($urandom % 8) + 1 : steps[i].hold;
      u_checker.start_test(names[i]);
      case (steps[i].port)
        PA: run_port(PA, steps[i], hold);
        PB: run_port(PB, steps[i], hold);
        default: begin
          fork
            run_port(PA, steps[i], hold);
            run_port(PB, steps[i], hold);
          join
        end
      endcase
      // One idle cycle so a stray second response is seen
      @(negedge clk);
      u_checker.finish_test();
    end
    fails = u_checker.error_count + dut_i.u_bridge_a.u_props.fail_count +
            dut_i.u_bridge_b.u_props.fail_count;
    u_checker.report();
    if (fails == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
